/* src/i2s_consts.svh */
`ifndef I2S_CONSTS_SVH
`define I2S_CONSTS_SVH

// Bits per channel sample
`define I2S_SAMPLE_W 16

// System clocks per half bit-clock period (bclk = clk_i / 16)
`define I2S_BCLK_HALF 8

// System clocks per channel half (lrclk = clk_i / 1024)
`define I2S_LRCLK_HALF 512

// Bit-clock periods per channel half, unused bits go out as zero
`define I2S_SLOT_BITS 32

`endif

/* src/audio_sample_pkg.sv */
`include "i2s_consts.svh"

package audio_sample_pkg;

  // One PCM sample, two's complement, as seen by the on-chip audio logic
  typedef logic signed [`I2S_SAMPLE_W-1:0] sample_t;

endpackage

/* src/i2s_frame_pkg.sv */
package i2s_frame_pkg;

  // Channel selected by the word clock level
  typedef enum logic {
    ch_left  = 1'b0,  // lrclk low
    ch_right = 1'b1   // lrclk high
  } channel_e;

endpackage

/* src/i2s_timing_if.sv */
interface i2s_timing_if;
  import i2s_frame_pkg::*;

  logic     bclk_rise;   // Cycle before bclk goes high
  logic     bclk_fall;   // Cycle before bclk goes low
  logic     lr_rise;     // Start of a right half
  logic     lr_fall;     // Start of a left half
  channel_e lr_channel;  // Current channel

  modport gen (
    output bclk_rise, bclk_fall, lr_rise, lr_fall, lr_channel
  );

  // DAC side only needs the shift and load points
  modport tx (
    input bclk_fall, lr_rise, lr_fall
  );

  modport rx (
    input bclk_rise, lr_rise, lr_fall, lr_channel
  );

endinterface

/* src/i2s_clock_gen.sv */
`include "i2s_consts.svh"

module i2s_clock_gen (
  input  logic         clk_i,
  input  logic         rst_ni,
  output logic         mclk,
  output logic         bclk,
  output logic         lrclk,
  i2s_timing_if.gen    timing
);
  import i2s_frame_pkg::*;

  logic [$clog2(`I2S_BCLK_HALF)-1:0]  bclk_cnt;
  logic [$clog2(`I2S_LRCLK_HALF)-1:0] lr_cnt;

  // Codec master clock at half the system rate
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mclk <= 1'b0;
    end else begin
      mclk <= ~mclk;
    end
  end

  // Bit clock, toggles when the counter runs out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bclk_cnt <= ($bits(bclk_cnt))'(`I2S_BCLK_HALF - 1);
      bclk     <= 1'b0;
    end else if (bclk_cnt == '0) begin
      bclk_cnt <= ($bits(bclk_cnt))'(`I2S_BCLK_HALF - 1);
      bclk     <= ~bclk;
    end else begin
      bclk_cnt <= bclk_cnt - 1'b1;
    end
  end

  // Word clock, 64 bclk half-periods per channel half so it always
  // toggles together with a bclk fall
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lr_cnt <= ($bits(lr_cnt))'(`I2S_LRCLK_HALF - 1);
      lrclk  <= 1'b0;
    end else if (lr_cnt == '0) begin
      lr_cnt <= ($bits(lr_cnt))'(`I2S_LRCLK_HALF - 1);
      lrclk  <= ~lrclk;
    end else begin
      lr_cnt <= lr_cnt - 1'b1;
    end
  end

  // Strobes lead the clock edge by one cycle
  assign timing.bclk_rise  = (bclk_cnt == '0) && !bclk;
  assign timing.bclk_fall  = (bclk_cnt == '0) && bclk;
  assign timing.lr_rise    = (lr_cnt == '0) && !lrclk;
  assign timing.lr_fall    = (lr_cnt == '0) && lrclk;
  assign timing.lr_channel = channel_e'(lrclk);

endmodule

/* src/i2s_transmitter.sv */
`include "i2s_consts.svh"

module i2s_transmitter (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  i2s_timing_if.tx                  timing,
  input  audio_sample_pkg::sample_t data_i_l,
  input  audio_sample_pkg::sample_t data_i_r,
  output logic                      dac_sdata
);

  // Delay bit on top of the sample
  logic [`I2S_SAMPLE_W:0] tx_shreg;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_shreg <= '0;
    end else if (timing.lr_rise) begin
      tx_shreg <= {1'b0, data_i_r};  // Right half starts
    end else if (timing.lr_fall) begin
      tx_shreg <= {1'b0, data_i_l};  // Left half starts
    end else if (timing.bclk_fall) begin
      // Zero fill keeps the line low after the LSB
      tx_shreg <= {tx_shreg[`I2S_SAMPLE_W-1:0], 1'b0};
    end
  end

  // The word clock edge shares its cycle with a bclk fall, the load wins
  // there so the delay bit stays on the line for one full bit period
  assign dac_sdata = tx_shreg[`I2S_SAMPLE_W];

endmodule

/* src/i2s_receiver.sv */
`include "i2s_consts.svh"

module i2s_receiver (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  i2s_timing_if.rx                  timing,
  input  logic                      adc_sdata,
  output audio_sample_pkg::sample_t data_o_l,
  output audio_sample_pkg::sample_t data_o_r,
  output logic                      frame_valid
);
  import audio_sample_pkg::*;
  import i2s_frame_pkg::*;

  logic [$clog2(`I2S_SLOT_BITS)-1:0] rise_cnt;  // Bit clock rises seen in this half
  sample_t                            rx_shreg;
  logic                               lr_edge;
  logic                               in_data;
  logic                               at_commit;

  assign lr_edge = timing.lr_rise || timing.lr_fall;

  // Count 0 is the delay bit, counts 1 to 16 carry the sample MSB first
  assign in_data   = (rise_cnt != '0) &&
                     (rise_cnt <= ($bits(rise_cnt))'(`I2S_SAMPLE_W));
  assign at_commit = (rise_cnt == ($bits(rise_cnt))'(`I2S_SAMPLE_W + 1));

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rise_cnt <= '0;
      rx_shreg <= '0;
    end else if (lr_edge) begin
      rise_cnt <= '0;
      rx_shreg <= '0;
    end else if (timing.bclk_rise) begin
      if (rise_cnt != '1) begin
        rise_cnt <= rise_cnt + 1'b1;  // Hold at the top until the next edge
      end
      if (in_data) begin
        rx_shreg <= {rx_shreg[`I2S_SAMPLE_W-2:0], adc_sdata};
      end
    end
  end

  // Output words, written once per half on the rise after the LSB
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_o_l    <= '0;
      data_o_r    <= '0;
      frame_valid <= 1'b0;
    end else if (timing.lr_fall) begin
      frame_valid <= 1'b0;  // New frame starts with the left half
    end else if (timing.bclk_rise && at_commit) begin
      if (timing.lr_channel == ch_right) begin
        data_o_r    <= rx_shreg;
        frame_valid <= 1'b1;  // Both channels of the frame are in
      end else begin
        data_o_l <= rx_shreg;
      end
    end
  end

endmodule

/* src/i2s_codec_port.sv */
module i2s_codec_port (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Codec side
  output logic                      mclk,
  output logic                      bclk,
  output logic                      lrclk,
  input  logic                      adc_sdata,
  output logic                      dac_sdata,
  // On-chip audio side
  input  audio_sample_pkg::sample_t data_i_l,
  input  audio_sample_pkg::sample_t data_i_r,
  output audio_sample_pkg::sample_t data_o_l,
  output audio_sample_pkg::sample_t data_o_r,
  output logic                      frame_valid
);

  i2s_timing_if timing_if ();  // Strobes shared by all three blocks

  i2s_clock_gen i2s_clock_gen_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mclk   (mclk),
    .bclk   (bclk),
    .lrclk  (lrclk),
    .timing (timing_if.gen)
  );

  i2s_transmitter i2s_transmitter_inst (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .timing    (timing_if.tx),
    .data_i_l  (data_i_l),
    .data_i_r  (data_i_r),
    .dac_sdata (dac_sdata)
  );

  i2s_receiver i2s_receiver_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .timing      (timing_if.rx),
    .adc_sdata   (adc_sdata),
    .data_o_l    (data_o_l),
    .data_o_r    (data_o_r),
    .frame_valid (frame_valid)
  );

endmodule

/* verif/i2s_codec_port_properties.sv */
module i2s_codec_port_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic bclk,
  input logic lrclk,
  input logic bclk_rise,
  input logic bclk_fall,
  input logic lr_rise,
  input logic lr_fall
);

  // One word clock direction at a time
  lr_exclusive_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(lr_rise && lr_fall)
  ) else $error("lr_rise and lr_fall high in the same cycle");

  bclk_rise_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) bclk_rise |=> $rose(bclk)
  ) else $error("bclk did not rise one cycle after bclk_rise");

  bclk_fall_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) bclk_fall |=> $fell(bclk)
  ) else $error("bclk did not fall one cycle after bclk_fall");

  // Word clock moves only together with a bit clock fall
  lr_on_bclk_fall_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (lr_rise || lr_fall) |-> bclk_fall
  ) else $error("word clock strobe without bclk_fall");

  lr_toggle_a : assert property (
    @(posedge clk_i) disable iff (!rst_ni) (lr_rise || lr_fall) |=> (lrclk != $past(lrclk))
  ) else $error("lrclk did not toggle one cycle after its strobe");

endmodule

bind i2s_clock_gen i2s_codec_port_properties i2s_codec_port_properties_inst (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .bclk      (bclk),
  .lrclk     (lrclk),
  .bclk_rise (timing.bclk_rise),
  .bclk_fall (timing.bclk_fall),
  .lr_rise   (timing.lr_rise),
  .lr_fall   (timing.lr_fall)
);

/* verif/tb_i2s_codec_port.sv */
`include "i2s_consts.svh"

module tb_i2s_codec_port;

  localparam int frames_to_run = 12;
  localparam int cycle_limit   = (2 * frames_to_run + 3) * `I2S_LRCLK_HALF;

  localparam int t_reset  = 0;
  localparam int t_clocks = 1;
  localparam int t_dac    = 2;
  localparam int t_adc    = 3;
  localparam int t_valid  = 4;

  logic                     clk_i = 1'b0;  // Low from the start so time 0 has no clock edge
  logic                     rst_ni;
  logic                     mclk;
  logic                     bclk;
  logic                     lrclk;
  logic                     adc_sdata;
  logic                     dac_sdata;
  logic                     frame_valid;
  logic [`I2S_SAMPLE_W-1:0] data_i_l;
  logic [`I2S_SAMPLE_W-1:0] data_i_r;
  logic [`I2S_SAMPLE_W-1:0] data_o_l;
  logic [`I2S_SAMPLE_W-1:0] data_o_r;

  integer seed;

  // Codec model and checker state
  logic                     prev_mclk;
  logic                     prev_bclk;
  logic                     prev_lrclk;
  int                       bclk_gap;      // Cycles since the last bclk edge
  int                       lr_gap;
  int                       fall_idx;      // Bit clock falls since the word clock edge
  int                       rise_idx;
  int                       halves;        // Word clock edges seen
  logic [`I2S_SAMPLE_W-1:0] exp_dac_word;
  logic [`I2S_SAMPLE_W-1:0] dac_word;
  logic [`I2S_SAMPLE_W-1:0] adc_word;      // Word the codec sends in this half
  logic [`I2S_SAMPLE_W-1:0] exp_o_l;
  logic [`I2S_SAMPLE_W-1:0] exp_o_r;

  string test_name [5] = '{"reset", "clocks", "dac", "adc", "valid"};
  int    err_cnt   [5];

  i2s_codec_port i2s_codec_port_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .mclk        (mclk),
    .bclk        (bclk),
    .lrclk       (lrclk),
    .adc_sdata   (adc_sdata),
    .dac_sdata   (dac_sdata),
    .data_i_l    (data_i_l),
    .data_i_r    (data_i_r),
    .data_o_l    (data_o_l),
    .data_o_r    (data_o_r),
    .frame_valid (frame_valid)
  );

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  task automatic report_mismatch(input int t, input string what,
                                 input logic [31:0] exp, input logic [31:0] act);
    err_cnt[t]++;
    $display("MISMATCH %s %s: expected %0h actual %0h", test_name[t], what, exp, act);
  endtask

  task automatic report_failure(input int t, input string what);
    err_cnt[t]++;
    $display("ERROR %s: %s", test_name[t], what);
  endtask

  function automatic logic [`I2S_SAMPLE_W-1:0] random_sample();
    logic [31:0] r;
    r = $random(seed);
    return r[`I2S_SAMPLE_W-1:0];
  endfunction

  // Serial line value after the given number of bclk falls into a half
  function automatic logic serial_bit(input int falls, input logic [`I2S_SAMPLE_W-1:0] word);
    logic [`I2S_SAMPLE_W-1:0] w;
    w = word << (falls - 1);
    if (falls >= 1 && falls <= `I2S_SAMPLE_W) begin
      return w[`I2S_SAMPLE_W-1];
    end
    return 1'b0;  // Delay bit and padding
  endfunction

  task automatic check_reset_state(input string when);
    if ({mclk, bclk, lrclk, dac_sdata, frame_valid} !== 5'b0) begin
      report_mismatch(t_reset, {"mclk,bclk,lrclk,dac_sdata,frame_valid ", when}, 32'h0,
                      32'({mclk, bclk, lrclk, dac_sdata, frame_valid}));
    end
    if (data_o_l !== '0) begin
      report_mismatch(t_reset, {"data_o_l ", when}, 32'h0, 32'(data_o_l));
    end
    if (data_o_r !== '0) begin
      report_mismatch(t_reset, {"data_o_r ", when}, 32'h0, 32'(data_o_r));
    end
  endtask

  // Codec model step for one system clock on the falling edge
  task automatic step_model();
    logic  bclk_rose;
    logic  bclk_fell;
    logic  lr_edge;
    string ch;
    bclk_rose = bclk && !prev_bclk;
    bclk_fell = !bclk && prev_bclk;
    lr_edge   = (lrclk != prev_lrclk);
    ch        = lrclk ? "right" : "left";
    bclk_gap++;
    lr_gap++;

    if (mclk == prev_mclk) begin
      report_failure(t_clocks, "mclk did not toggle in this cycle");
    end
    if (bclk != prev_bclk) begin
      if (bclk_gap != `I2S_BCLK_HALF) begin
        report_mismatch(t_clocks, "bclk interval", `I2S_BCLK_HALF, bclk_gap);
      end
      bclk_gap = 0;
    end
    if (lr_edge) begin
      if (lr_gap != `I2S_LRCLK_HALF) begin
        report_mismatch(t_clocks, "lrclk interval", `I2S_LRCLK_HALF, lr_gap);
      end
      if (!bclk_fell) begin
        report_failure(t_clocks, "lrclk changed without a bclk fall");
      end
      lr_gap = 0;
    end

    if (bclk_fell) begin
      if (lr_edge) begin
        // The half that just ended has been captured by now
        if (prev_lrclk) begin
          exp_o_r = adc_word;
        end else begin
          exp_o_l = adc_word;
        end
        if (data_o_l !== exp_o_l) begin
          report_mismatch(t_adc, "data_o_l", 32'(exp_o_l), 32'(data_o_l));
        end
        if (data_o_r !== exp_o_r) begin
          report_mismatch(t_adc, "data_o_r", 32'(exp_o_r), 32'(data_o_r));
        end
        halves++;
        fall_idx     = 0;
        rise_idx     = 0;
        exp_dac_word = lrclk ? data_i_r : data_i_l;  // Held since mid half
        adc_word     = random_sample();
      end else begin
        fall_idx++;
      end
      adc_sdata = serial_bit(fall_idx, adc_word);
      if (fall_idx == `I2S_SLOT_BITS / 2) begin
        if (frame_valid !== 1'b0) begin
          report_mismatch(t_valid, {"level at mid ", ch, " half"}, 32'h0, 32'(frame_valid));
        end
        data_i_l = random_sample();
        data_i_r = random_sample();
      end
    end

    if (bclk_rose) begin
      rise_idx++;
      if (halves > 0) begin
        if (rise_idx >= 2 && rise_idx <= `I2S_SAMPLE_W + 1) begin
          dac_word = {dac_word[`I2S_SAMPLE_W-2:0], dac_sdata};
          if (rise_idx == `I2S_SAMPLE_W + 1 && dac_word !== exp_dac_word) begin
            report_mismatch(t_dac, {ch, " word"}, 32'(exp_dac_word), 32'(dac_word));
          end
        end else if (dac_sdata !== 1'b0) begin
          report_mismatch(t_dac, $sformatf("%s bit %0d", ch, rise_idx), 32'h0,
                          32'(dac_sdata));
        end
        if (rise_idx == `I2S_SLOT_BITS && frame_valid !== lrclk) begin
          report_mismatch(t_valid, {"level at end of ", ch, " half"}, 32'(lrclk),
                          32'(frame_valid));
        end
      end
    end

    prev_mclk  = mclk;
    prev_bclk  = bclk;
    prev_lrclk = lrclk;
  endtask

  initial begin
    int cyc;
    int total;
    seed         = 32'h356b;
    rst_ni       = 1'b0;
    adc_sdata    = 1'b0;
    data_i_l     = '0;
    data_i_r     = '0;
    prev_mclk    = 1'b0;
    prev_bclk    = 1'b0;
    prev_lrclk   = 1'b0;
    bclk_gap     = 0;
    lr_gap       = 0;
    fall_idx     = 0;
    rise_idx     = 0;
    halves       = 0;
    exp_dac_word = '0;
    dac_word     = '0;
    adc_word     = '0;  // Nothing sent before the first word clock edge
    exp_o_l      = '0;
    exp_o_r      = '0;
    foreach (err_cnt[i]) begin
      err_cnt[i] = 0;
    end

    for (cyc = 0; cyc < 16; cyc++) begin
      @(negedge clk_i);
      check_reset_state("during reset");
    end
    rst_ni = 1'b1;
    #1;  // Still before the next rising edge
    check_reset_state("after release");
    $display("test %s finished, %0d errors", test_name[t_reset], err_cnt[t_reset]);

    data_i_l = random_sample();
    data_i_r = random_sample();

    // One extra edge so the capture of the last half is checked
    cyc = 0;
    while (halves <= 2 * frames_to_run && cyc < cycle_limit) begin
      @(negedge clk_i);
      cyc++;
      step_model();
    end
    if (halves <= 2 * frames_to_run) begin
      report_failure(t_clocks, $sformatf("timeout after %0d cycles, only %0d word clock edges",
                                         cyc, halves));
    end

    for (int t = 1; t < 5; t++) begin
      $display("test %s finished, %0d errors", test_name[t], err_cnt[t]);
    end
    total = 0;
    foreach (err_cnt[i]) begin
      total += err_cnt[i];
    end
    $display("Totals: reset %0d, clocks %0d, dac %0d, adc %0d, valid %0d, all %0d errors",
             err_cnt[0], err_cnt[1], err_cnt[2], err_cnt[3], err_cnt[4], total);
    if (total == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* i2s_codec_port.f */
+incdir+src
src/audio_sample_pkg.sv
src/i2s_frame_pkg.sv
src/i2s_timing_if.sv
src/i2s_clock_gen.sv
src/i2s_transmitter.sv
src/i2s_receiver.sv
src/i2s_codec_port.sv
verif/i2s_codec_port_properties.sv
verif/tb_i2s_codec_port.sv

/* Makefile */
TOP = tb_i2s_codec_port

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f i2s_codec_port.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir
